// ==== sources.f ====
design/hps_io_pkg.sv
design/hps_cmd_frame.sv
design/hps_config_regs.sv
design/hps_ps2_key.sv
design/hps_file_loader.sv
design/hps_io.sv
testbench/hps_io_assertions.sv
testbench/hps_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hps_io testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module hps_io_tb -f sources.f -o hps_io_sim

./obj_dir/hps_io_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "run passed"
else
	echo "run failed, see sim.log"
	exit 1
fi

// ==== testbench/hps_io_tb.sv ====
`timescale 1ns/1ps

module hps_io_tb;

	localparam int max_cycles = 20000;

	logic                    clk_sys;
	logic                    reset;
	logic                    io_enable;
	logic                    io_strobe;
	hps_io_pkg::word_t       io_din;
	hps_io_pkg::word_t       io_dout;
	logic                    io_wait;
	hps_io_pkg::joy_t        joystick_0;
	hps_io_pkg::joy_t        joystick_1;
	hps_io_pkg::joy_t        joystick_2;
	hps_io_pkg::joy_t        joystick_3;
	hps_io_pkg::joy_t        joystick_4;
	hps_io_pkg::joy_t        joystick_5;
	hps_io_pkg::word_t       joy_raw;
	logic [1:0]              buttons;
	logic                    forced_scandoubler;
	hps_io_pkg::status_t     status;
	hps_io_pkg::status_t     status_in;
	logic                    status_set;
	hps_io_pkg::ps2_key_t    ps2_key;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic [31:0]             ioctl_file_ext;
	logic                    ioctl_wr;
	hps_io_pkg::ioctl_addr_t ioctl_addr;
	hps_io_pkg::ioctl_data_t ioctl_dout;
	logic                    ioctl_wait;

	int                      errors = 0;
	int                      cycle_cnt = 0;
	int                      wr_seen = 0;
	logic [31:0]             rng;
	logic                    bp_on;
	hps_io_pkg::word_t       tx_buf [64];
	hps_io_pkg::word_t       rx_buf [64];
	hps_io_pkg::ioctl_data_t exp_bytes [$];
	hps_io_pkg::ps2_key_t    exp_key;

	hps_io hps_io_inst (.*);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// helpers and reference model
	////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	function automatic hps_io_pkg::joy_t joy_ref(input hps_io_pkg::word_t lo,
		input hps_io_pkg::word_t hi);
		return {hi, lo};
	endfunction

	function automatic hps_io_pkg::status_t status_ref(input hps_io_pkg::word_t w1,
		input hps_io_pkg::word_t w2, input hps_io_pkg::word_t w3,
		input hps_io_pkg::word_t w4);
		return {w4, w3, w2, w1};
	endfunction

	// only the low byte of a data word reaches the core
	function automatic hps_io_pkg::ioctl_data_t dl_byte_ref(input hps_io_pkg::word_t w);
		return w[7:0];
	endfunction

	function automatic hps_io_pkg::ps2_key_t ps2_ref(input logic [63:0] seq, input int n,
		input hps_io_pkg::ps2_key_t prev);
		logic [31:0] last4;
		logic        released;
		logic        ext;
		logic [9:0]  code;
		last4 = '0;
		for (int k = 0; k < n; k++) begin
			last4 = {last4[23:0], seq[(n - 1 - k) * 8 +: 8]};
		end
		released = (last4[15:8] == hps_io_pkg::ps2_release);
		ext = released ? (last4[23:16] == hps_io_pkg::ps2_ext)
		               : (last4[15:8] == hps_io_pkg::ps2_ext);
		code = {~released, ext, last4[7:0]};
		if (last4 == hps_io_pkg::prnscr_make) begin
			code = hps_io_pkg::prnscr_make_code;
		end else if (last4 == hps_io_pkg::prnscr_break) begin
			code = hps_io_pkg::prnscr_break_code;
		end else if (last4 == hps_io_pkg::pause_make) begin
			code = hps_io_pkg::pause_make_code;
		end
		return {~prev[10], code};
	endfunction

	function automatic hps_io_pkg::joy_t joy_out(input int j);
		case (j)
			0: return joystick_0;
			1: return joystick_1;
			2: return joystick_2;
			3: return joystick_3;
			4: return joystick_4;
			default: return joystick_5;
		endcase
	endfunction

	////////////////////////////////////////
	// host bus driver
	////////////////////////////////////////

	// read data shows up two edges after the strobe is driven
	task automatic send_frame(input int n);
		int          sent;
		int          pend1;
		int          pend2;
		logic [31:0] r;
		sent = 0;
		pend1 = -1;
		pend2 = -1;
		@(posedge clk_sys);
		io_enable <= 1'b1;
		while (sent < n || pend1 >= 0 || pend2 >= 0) begin
			@(posedge clk_sys);
			// core back-pressure is passed straight to the host
			check_value("io_wait", 64'(io_wait), 64'(ioctl_wait));
			if (pend2 >= 0) begin
				rx_buf[pend2] = io_dout;
			end
			pend2 = pend1;
			pend1 = -1;
			if (bp_on) begin
				r = next_rand();
				ioctl_wait <= r[20] & r[21];
			end
			if (sent < n && !io_wait) begin
				io_din    <= tx_buf[sent];
				io_strobe <= 1'b1;
				pend1 = sent;
				sent++;
			end else begin
				io_strobe <= 1'b0;
			end
		end
		io_enable  <= 1'b0;
		ioctl_wait <= 1'b0;
		// frame_end and the key event settle in here
		repeat (3) @(posedge clk_sys);
		// read bus is back at zero outside a frame
		check_value("io_dout", 64'(io_dout), 64'd0);
	endtask

	////////////////////////////////////////
	// test sequences
	////////////////////////////////////////

	task automatic config_tests();
		logic [31:0]       r;
		hps_io_pkg::word_t w [5];
		hps_io_pkg::cmd_t  joy_cmds [6];
		joy_cmds = '{hps_io_pkg::cmd_joy_0, hps_io_pkg::cmd_joy_1, hps_io_pkg::cmd_joy_2,
			hps_io_pkg::cmd_joy_3, hps_io_pkg::cmd_joy_4, hps_io_pkg::cmd_joy_5};
		repeat (3) begin
			r = next_rand();
			tx_buf[0] = hps_io_pkg::cmd_cfg;
			tx_buf[1] = r[15:0];
			send_frame(2);
			check_value("buttons", 64'(buttons), 64'(r[1:0]));
			check_value("forced_scandoubler", 64'(forced_scandoubler), 64'(r[4]));
		end
		for (int j = 0; j < 6; j++) begin
			r = next_rand();
			tx_buf[0] = joy_cmds[j];
			tx_buf[1] = r[15:0];
			tx_buf[2] = r[31:16];
			send_frame(3);
			check_value($sformatf("joystick_%0d", j), 64'(joy_out(j)),
				64'(joy_ref(r[15:0], r[31:16])));
		end
		tx_buf[0] = hps_io_pkg::cmd_status;
		for (int k = 1; k <= 4; k++) begin
			r = next_rand();
			w[k] = r[31:16];
			tx_buf[k] = w[k];
		end
		send_frame(5);
		check_value("status", status, status_ref(w[1], w[2], w[3], w[4]));
	endtask

	task automatic status_req_tests();
		hps_io_pkg::status_t s;
		logic [31:0]         r;
		for (int req = 1; req <= 3; req++) begin
			s[31:0] = next_rand();
			s[63:32] = next_rand();
			@(posedge clk_sys);
			status_in  <= s;
			status_set <= 1'b1;
			// held for two edges, must still count once
			repeat (2) @(posedge clk_sys);
			status_set <= 1'b0;
			tx_buf[0] = hps_io_pkg::cmd_status_req;
			for (int k = 1; k <= 4; k++) begin
				tx_buf[k] = 16'h0000;
			end
			send_frame(5);
			check_value("io_dout", 64'(rx_buf[0]),
				64'({8'h00, hps_io_pkg::status_req_tag, req[3:0]}));
			for (int k = 1; k <= 4; k++) begin
				check_value($sformatf("io_dout word %0d", k), 64'(rx_buf[k]),
					64'(s[(k - 1) * 16 +: 16]));
			end
		end
		r = next_rand();
		@(posedge clk_sys);
		joy_raw <= r[15:0];
		tx_buf[0] = hps_io_pkg::cmd_joy_raw;
		tx_buf[1] = 16'h0000;
		send_frame(2);
		check_value("io_dout", 64'(rx_buf[1]), 64'(r[15:0]));
	endtask

	// seq holds the bytes oldest first, right aligned
	task automatic send_keys(input logic [63:0] seq, input int n, input bit skip);
		int pos;
		tx_buf[0] = hps_io_pkg::cmd_ps2_key;
		pos = 1;
		for (int k = 0; k < n; k++) begin
			if (skip && k == 1) begin
				tx_buf[pos] = {hps_io_pkg::ps2_skip_mark, 8'h00};
				pos++;
			end
			tx_buf[pos] = {8'h00, seq[(n - 1 - k) * 8 +: 8]};
			pos++;
		end
		send_frame(pos);
		if (!skip) begin
			exp_key = ps2_ref(seq, n, exp_key);
		end
		check_value("ps2_key", 64'(ps2_key), 64'(exp_key));
	endtask

	task automatic key_tests();
		send_keys(64'h1C, 1, 1'b0);
		send_keys(64'hF01C, 2, 1'b0);
		send_keys(64'hE075, 2, 1'b0);
		send_keys(64'hE0F075, 3, 1'b0);
		send_keys(64'hE012E07C, 4, 1'b0);
		send_keys(64'hE0F07CE0F012, 6, 1'b0);
		send_keys(64'hE11477E1F014F077, 8, 1'b0);
		send_keys(64'h2A1C, 2, 1'b1);
		send_keys(64'h29, 1, 1'b0);
	endtask

	task automatic download_test(input bit with_wait);
		logic [31:0] r;
		int          n;
		r = next_rand();
		n = 8 + int'(r[27:23]);
		tx_buf[0] = hps_io_pkg::cmd_file_index;
		tx_buf[1] = {8'h00, r[7:0]};
		send_frame(2);
		check_value("ioctl_index", 64'(ioctl_index), 64'(r[7:0]));
		r = next_rand();
		tx_buf[0] = hps_io_pkg::cmd_file_info;
		tx_buf[1] = r[31:16];
		tx_buf[2] = r[15:0];
		send_frame(3);
		check_value("ioctl_file_ext", 64'(ioctl_file_ext), 64'(r));
		tx_buf[0] = hps_io_pkg::cmd_file_tx;
		tx_buf[1] = 16'h0001;
		send_frame(2);
		check_value("ioctl_download", 64'(ioctl_download), 64'd1);
		tx_buf[0] = hps_io_pkg::cmd_file_tx_dat;
		for (int k = 1; k <= n; k++) begin
			r = next_rand();
			tx_buf[k] = r[31:16];
			exp_bytes.push_back(dl_byte_ref(r[31:16]));
		end
		bp_on = with_wait;
		send_frame(n + 1);
		bp_on = 1'b0;
		check_value("ioctl write count", 64'(wr_seen), 64'(n));
		tx_buf[0] = hps_io_pkg::cmd_file_tx;
		tx_buf[1] = 16'h0000;
		send_frame(2);
		check_value("ioctl_download", 64'(ioctl_download), 64'd0);
		check_value("ioctl_addr", 64'(ioctl_addr), 64'(n - 1));
	endtask

	////////////////////////////////////////
	// write port monitor and timeout
	////////////////////////////////////////

	initial begin
		forever begin
			@(posedge clk_sys);
			if (!ioctl_download) begin
				wr_seen = 0;
			end else if (ioctl_wr) begin
				if (exp_bytes.size() == 0) begin
					errors++;
					$display("ioctl write at address %h was not expected", ioctl_addr);
				end else begin
					check_value("ioctl_dout", 64'(ioctl_dout), 64'(exp_bytes.pop_front()));
					check_value("ioctl_addr", 64'(ioctl_addr), 64'(wr_seen));
				end
				wr_seen++;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= max_cycles) begin
			$display("timeout after %0d cycles, test sequence did not finish", cycle_cnt);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		rng = 32'd7414;
		bp_on = 1'b0;
		exp_key = '0;
		reset      <= 1'b1;
		io_enable  <= 1'b0;
		io_strobe  <= 1'b0;
		io_din     <= '0;
		joy_raw    <= '0;
		status_in  <= '0;
		status_set <= 1'b0;
		ioctl_wait <= 1'b0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		check_value("io_dout", 64'(io_dout), 64'd0);
		check_value("ioctl_wr", 64'(ioctl_wr), 64'd0);
		check_value("ioctl_download", 64'(ioctl_download), 64'd0);
		check_value("ps2_key", 64'(ps2_key), 64'd0);
		config_tests();
		status_req_tests();
		key_tests();
		download_test(1'b0);
		download_test(1'b1);
		repeat (4) @(posedge clk_sys);
		$display("checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== testbench/hps_io_assertions.sv ====
`timescale 1ns/1ps

module hps_io_assertions (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  hps_io_pkg::ioctl_addr_t ioctl_addr,
	input  logic                    frame_end,
	input  hps_io_pkg::word_t       io_dout
);

	// address of the previous write within the current download
	hps_io_pkg::ioctl_addr_t last_addr;
	logic                    wr_seen;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			last_addr <= '0;
			wr_seen   <= 1'b0;
		end else if (!ioctl_download) begin
			wr_seen <= 1'b0;
		end else if (ioctl_wr) begin
			last_addr <= ioctl_addr;
			wr_seen   <= 1'b1;
		end
	end

	wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl write pulse outside of a download");

	dout_cleared: assert property (@(posedge clk_sys) disable iff (reset)
		frame_end |=> (io_dout == '0))
		else $error("read bus not cleared after the end of a frame");

	addr_step: assert property (@(posedge clk_sys) disable iff (reset)
		(ioctl_wr && wr_seen) |-> (ioctl_addr == last_addr + 27'd1))
		else $error("ioctl write address did not advance by one");

endmodule

// download port checks, the read bus is tied off here
bind hps_file_loader hps_io_assertions loader_checks (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.ioctl_download (ioctl_download),
	.ioctl_wr       (ioctl_wr),
	.ioctl_addr     (ioctl_addr),
	.frame_end      (1'b0),
	.io_dout        (16'h0000)
);

// read bus checks, the download port is tied off here
bind hps_config_regs hps_io_assertions readback_checks (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.ioctl_download (1'b0),
	.ioctl_wr       (1'b0),
	.ioctl_addr     (27'd0),
	.frame_end      (frame_end),
	.io_dout        (io_dout)
);

// ==== design/hps_io.sv ====
`timescale 1ns/1ps

module hps_io (
	input  logic                    clk_sys,
	input  logic                    reset,

	// host bus
	input  logic                    io_enable,
	input  logic                    io_strobe,
	input  hps_io_pkg::word_t       io_din,
	output hps_io_pkg::word_t       io_dout,
	output logic                    io_wait,

	// core configuration
	output hps_io_pkg::joy_t        joystick_0,
	output hps_io_pkg::joy_t        joystick_1,
	output hps_io_pkg::joy_t        joystick_2,
	output hps_io_pkg::joy_t        joystick_3,
	output hps_io_pkg::joy_t        joystick_4,
	output hps_io_pkg::joy_t        joystick_5,
	input  hps_io_pkg::word_t       joy_raw,
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output hps_io_pkg::status_t     status,
	input  hps_io_pkg::status_t     status_in,
	input  logic                    status_set,
	output hps_io_pkg::ps2_key_t    ps2_key,

	// download port
	output logic                    ioctl_download,
	output logic [7:0]              ioctl_index,
	output logic [31:0]             ioctl_file_ext,
	output logic                    ioctl_wr,
	output hps_io_pkg::ioctl_addr_t ioctl_addr,
	output hps_io_pkg::ioctl_data_t ioctl_dout,
	input  logic                    ioctl_wait
);

	logic                  first_word;
	logic                  word_valid;
	logic                  frame_end;
	hps_io_pkg::cmd_t      cur_cmd;
	hps_io_pkg::word_cnt_t word_cnt;

	// core back-pressure goes straight to the host
	assign io_wait = ioctl_wait;

	hps_cmd_frame hps_cmd_frame_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.first_word (first_word),
		.word_valid (word_valid),
		.frame_end  (frame_end),
		.cur_cmd    (cur_cmd),
		.word_cnt   (word_cnt)
	);

	hps_config_regs hps_config_regs_inst (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.first_word         (first_word),
		.word_valid         (word_valid),
		.frame_end          (frame_end),
		.cur_cmd            (cur_cmd),
		.word_cnt           (word_cnt),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.joy_raw            (joy_raw),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set)
	);

	hps_ps2_key hps_ps2_key_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.first_word (first_word),
		.word_valid (word_valid),
		.frame_end  (frame_end),
		.cur_cmd    (cur_cmd),
		.io_din     (io_din),
		.ps2_key    (ps2_key)
	);

	hps_file_loader hps_file_loader_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.word_valid     (word_valid),
		.cur_cmd        (cur_cmd),
		.word_cnt       (word_cnt),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// ==== design/hps_file_loader.sv ====
`timescale 1ns/1ps

module hps_file_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   word_valid,
	input  hps_io_pkg::cmd_t       cur_cmd,
	input  hps_io_pkg::word_cnt_t  word_cnt,
	input  hps_io_pkg::word_t      io_din,
	output logic                   ioctl_download,
	output logic                   ioctl_wr,
	output logic [7:0]             ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output hps_io_pkg::ioctl_addr_t ioctl_addr,
	output hps_io_pkg::ioctl_data_t ioctl_dout
);

	hps_io_pkg::dl_state_t   dl_state;
	hps_io_pkg::ioctl_addr_t addr;
	logic                    tx_start;

	// any nonzero low byte opens a transfer
	assign tx_start = |io_din[7:0];

	assign ioctl_download = (dl_state == hps_io_pkg::dl_active);

	////////////////////////////////////////
	// file description
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
		end else if (word_valid) begin
			if (cur_cmd == hps_io_pkg::cmd_file_index) begin
				ioctl_index <= io_din[7:0];
			end
			// extension comes high half first
			if (cur_cmd == hps_io_pkg::cmd_file_info) begin
				if (word_cnt == 10'd1) begin
					ioctl_file_ext[31:16] <= io_din;
				end else if (word_cnt == 10'd2) begin
					ioctl_file_ext[15:0] <= io_din;
				end
			end
		end
	end

	////////////////////////////////////////
	// download state and write port
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_state   <= hps_io_pkg::dl_idle;
			addr       <= '0;
			ioctl_wr   <= 1'b0;
			ioctl_addr <= '0;
			ioctl_dout <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (word_valid) begin
				case (cur_cmd)
					hps_io_pkg::cmd_file_tx: begin
						if (tx_start) begin
							dl_state <= hps_io_pkg::dl_active;
							addr     <= '0;
						end else begin
							dl_state <= hps_io_pkg::dl_idle;
							// address of the last byte written
							ioctl_addr <= addr - 27'd1;
						end
					end
					hps_io_pkg::cmd_file_tx_dat: begin
						if (dl_state == hps_io_pkg::dl_active) begin
							ioctl_addr <= addr;
							ioctl_dout <= io_din[7:0];
							ioctl_wr   <= 1'b1;
							addr       <= addr + 27'd1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== design/hps_ps2_key.sv ====
`timescale 1ns/1ps

module hps_ps2_key (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                first_word,
	input  logic                word_valid,
	input  logic                frame_end,
	input  hps_io_pkg::cmd_t    cur_cmd,
	input  hps_io_pkg::word_t   io_din,
	output hps_io_pkg::ps2_key_t ps2_key
);

	// last four bytes of the frame, newest in [7:0]
	logic [31:0] key_raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;
	logic        key_frame;

	assign key_frame = (cur_cmd == hps_io_pkg::cmd_ps2_key);

	assign pressed = (key_raw[15:8] != hps_io_pkg::ps2_release);

	// on a break the E0 prefix sits in front of the F0
	assign extended = pressed ? (key_raw[15:8] == hps_io_pkg::ps2_ext)
	                          : (key_raw[23:16] == hps_io_pkg::ps2_ext);

	// print screen and pause arrive as longer sequences
	always_comb begin
		case (key_raw)
			hps_io_pkg::prnscr_make:  key_code = hps_io_pkg::prnscr_make_code;
			hps_io_pkg::prnscr_break: key_code = hps_io_pkg::prnscr_break_code;
			hps_io_pkg::pause_make:   key_code = hps_io_pkg::pause_make_code;
			default:                  key_code = {pressed, extended, key_raw[7:0]};
		endcase
	end

	////////////////////////////////////////
	// byte collection
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_raw <= '0;
			skip    <= 1'b0;
		end else if (frame_end) begin
			skip <= 1'b0;
		end else if (first_word) begin
			skip <= 1'b0;
			if (io_din == hps_io_pkg::cmd_ps2_key) begin
				key_raw <= '0;
			end
		end else if (word_valid && key_frame) begin
			if (io_din[15:8] == hps_io_pkg::ps2_skip_mark) begin
				skip <= 1'b1;
			end else if (!skip) begin
				key_raw <= {key_raw[23:0], io_din[7:0]};
			end
		end
	end

	////////////////////////////////////////
	// key event
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2_key <= '0;
		end else if (frame_end && key_frame && !skip) begin
			ps2_key <= {~ps2_key[10], key_code};
		end
	end

endmodule

// ==== design/hps_config_regs.sv ====
`timescale 1ns/1ps

module hps_config_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   first_word,
	input  logic                   word_valid,
	input  logic                   frame_end,
	input  hps_io_pkg::cmd_t       cur_cmd,
	input  hps_io_pkg::word_cnt_t  word_cnt,
	input  hps_io_pkg::word_t      io_din,
	output hps_io_pkg::word_t      io_dout,
	output hps_io_pkg::joy_t       joystick_0,
	output hps_io_pkg::joy_t       joystick_1,
	output hps_io_pkg::joy_t       joystick_2,
	output hps_io_pkg::joy_t       joystick_3,
	output hps_io_pkg::joy_t       joystick_4,
	output hps_io_pkg::joy_t       joystick_5,
	input  hps_io_pkg::word_t      joy_raw,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output hps_io_pkg::status_t    status,
	input  hps_io_pkg::status_t    status_in,
	input  logic                   status_set
);

	logic [7:0]           cfg;
	hps_io_pkg::joy_t     joy_q [6];
	logic [2:0]           joy_sel;
	logic                 joy_hit;
	logic                 status_set_q;
	logic [3:0]           req_cnt;
	hps_io_pkg::status_t  status_req;
	hps_io_pkg::word_t    rd_word;

	// cfg[2], cfg[3] and cfg[5] belong to the system shell
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	assign joystick_0 = joy_q[0];
	assign joystick_1 = joy_q[1];
	assign joystick_2 = joy_q[2];
	assign joystick_3 = joy_q[3];
	assign joystick_4 = joy_q[4];
	assign joystick_5 = joy_q[5];

	// joystick command to register slot
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (cur_cmd)
			hps_io_pkg::cmd_joy_0: joy_sel = 3'd0;
			hps_io_pkg::cmd_joy_1: joy_sel = 3'd1;
			hps_io_pkg::cmd_joy_2: joy_sel = 3'd2;
			hps_io_pkg::cmd_joy_3: joy_sel = 3'd3;
			hps_io_pkg::cmd_joy_4: joy_sel = 3'd4;
			hps_io_pkg::cmd_joy_5: joy_sel = 3'd5;
			default:               joy_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// host writes
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg    <= '0;
			status <= '0;
			for (int i = 0; i < 6; i++) begin
				joy_q[i] <= '0;
			end
		end else if (word_valid) begin
			if (cur_cmd == hps_io_pkg::cmd_cfg && word_cnt == 10'd1) begin
				cfg <= io_din[7:0];
			end
			if (joy_hit) begin
				if (word_cnt == 10'd1) begin
					joy_q[joy_sel][15:0] <= io_din;
				end else if (word_cnt == 10'd2) begin
					joy_q[joy_sel][31:16] <= io_din;
				end
			end
			if (cur_cmd == hps_io_pkg::cmd_status) begin
				case (word_cnt)
					10'd1: status[15:0]  <= io_din;
					10'd2: status[31:16] <= io_din;
					10'd3: status[47:32] <= io_din;
					10'd4: status[63:48] <= io_din;
					default: ;
				endcase
			end
		end
	end

	// core asks for a status update, host polls the counter to notice it
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				req_cnt    <= req_cnt + 4'd1;
				status_req <= status_in;
			end
		end
	end

	////////////////////////////////////////
	// read-back
	////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		if (first_word) begin
			if (io_din == hps_io_pkg::cmd_status_req) begin
				rd_word = {8'h00, hps_io_pkg::status_req_tag, req_cnt};
			end
		end else begin
			case (cur_cmd)
				hps_io_pkg::cmd_status_req: begin
					case (word_cnt)
						10'd1: rd_word = status_req[15:0];
						10'd2: rd_word = status_req[31:16];
						10'd3: rd_word = status_req[47:32];
						10'd4: rd_word = status_req[63:48];
						default: ;
					endcase
				end
				hps_io_pkg::cmd_joy_raw: rd_word = joy_raw;
				default: ;
			endcase
		end
	end

	// answer holds until the next strobe, dropped once the frame closes
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (frame_end) begin
			io_dout <= '0;
		end else if (first_word || word_valid) begin
			io_dout <= rd_word;
		end
	end

endmodule

// ==== design/hps_cmd_frame.sv ====
`timescale 1ns/1ps

module hps_cmd_frame (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  hps_io_pkg::word_t      io_din,
	output logic                   first_word,
	output logic                   word_valid,
	output logic                   frame_end,
	output hps_io_pkg::cmd_t       cur_cmd,
	output hps_io_pkg::word_cnt_t  word_cnt
);

	// io_enable as seen on the previous cycle
	logic in_frame;

	logic strobe_in_frame;
	logic cnt_at_cmd;
	logic cnt_full;

	assign strobe_in_frame = io_enable & io_strobe;

	// the counter sits at zero until the command word has arrived
	assign cnt_at_cmd = (word_cnt == 10'd0);
	assign cnt_full   = (word_cnt == 10'h3FF);

	assign first_word = strobe_in_frame & cnt_at_cmd;
	assign word_valid = strobe_in_frame & ~cnt_at_cmd;

	// first low cycle of io_enable, cur_cmd is still intact here
	assign frame_end = in_frame & ~io_enable;

	////////////////////////////////////////
	// frame state
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			in_frame <= 1'b0;
		end else begin
			in_frame <= io_enable;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			word_cnt <= '0;
			cur_cmd  <= '0;
		end else if (!io_enable) begin
			word_cnt <= '0;
			cur_cmd  <= '0;
		end else if (io_strobe) begin
			// saturate, long frames keep reporting the last index
			if (!cnt_full) begin
				word_cnt <= word_cnt + 10'd1;
			end
			if (cnt_at_cmd) begin
				cur_cmd <= hps_io_pkg::cmd_t'(io_din);
			end
		end
	end

endmodule

// ==== design/hps_io_pkg.sv ====
package hps_io_pkg;

	////////////////////////////////////////
	// widths that carry a meaning
	////////////////////////////////////////

	typedef logic [15:0] word_t;
	typedef logic [15:0] cmd_t;
	typedef logic [9:0]  word_cnt_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [7:0]  ioctl_data_t;

	// [10] toggle, [9] pressed, [8] extended, [7:0] scan code
	typedef logic [10:0] ps2_key_t;

	typedef enum logic {
		dl_idle,
		dl_active
	} dl_state_t;

	////////////////////////////////////////
	// command codes
	////////////////////////////////////////

	localparam cmd_t cmd_cfg         = 16'h0001;
	localparam cmd_t cmd_joy_0       = 16'h0002;
	localparam cmd_t cmd_joy_1       = 16'h0003;
	localparam cmd_t cmd_ps2_key     = 16'h0005;
	localparam cmd_t cmd_joy_2       = 16'h0010;
	localparam cmd_t cmd_joy_3       = 16'h0011;
	localparam cmd_t cmd_joy_4       = 16'h0012;
	localparam cmd_t cmd_joy_5       = 16'h0013;
	localparam cmd_t cmd_status      = 16'h001E;
	localparam cmd_t cmd_status_req  = 16'h0029;
	localparam cmd_t cmd_joy_raw     = 16'h0037;
	localparam cmd_t cmd_file_tx     = 16'h0053;
	localparam cmd_t cmd_file_tx_dat = 16'h0054;
	localparam cmd_t cmd_file_index  = 16'h0055;
	localparam cmd_t cmd_file_info   = 16'h0056;

	// keyboard byte stream markers
	localparam logic [7:0] ps2_skip_mark = 8'hFF;
	localparam logic [7:0] ps2_release   = 8'hF0;
	localparam logic [7:0] ps2_ext       = 8'hE0;

	// multi-byte sequences folded into a single event
	localparam logic [31:0] prnscr_make       = 32'hE012E07C;
	localparam logic [31:0] prnscr_break      = 32'h7CE0F012;
	localparam logic [31:0] pause_make        = 32'hF014F077;
	localparam logic [9:0]  prnscr_make_code  = 10'h37C;
	localparam logic [9:0]  prnscr_break_code = 10'h17C;
	localparam logic [9:0]  pause_make_code   = 10'h377;

	localparam logic [3:0] status_req_tag = 4'hA;

endpackage
